//--- hw/ecc_pkg.sv
`default_nettype none

package ecc_pkg;

  localparam int amba_word = 32;  // every register and codeword fits

  typedef enum logic [1:0] {
    op_encode  = 2'd0,
    op_decode  = 2'd1,
    op_channel = 2'd2  // 3 reserved
  } ecc_op_t;

  typedef enum logic [1:0] {
    w8  = 2'd0,
    w16 = 2'd1,
    w32 = 2'd2
  } cw_width_t;

  // ----------------------------------------
  // codeword layout, bit 0 is overall parity
  // ----------------------------------------
  typedef struct packed {
    logic [amba_word-2:0] body;  // hamming positions 31..1
    logic                 parity;
  } codeword_t;

  typedef union packed {
    logic [amba_word-1:0] raw;  // data bits, low k used
    codeword_t            cw;
  } data_word_u;

  typedef struct packed {
    ecc_op_t              op;
    cw_width_t            width;
    data_word_u           data_in;
    logic [amba_word-1:0] noise;
  } ecc_cmd_t;

  typedef struct packed {
    ecc_op_t              op;
    cw_width_t            width;
    logic [amba_word-1:0] value;
    logic [1:0]           err_count;
  } ecc_core_out_t;

  typedef struct packed {
    logic [amba_word-1:0] data_out;
    logic [1:0]           num_of_errors;
    logic                 done;
  } ecc_result_t;

  function automatic logic [amba_word-1:0] cw_mask(cw_width_t w);
    case (w)
      w8:      return 32'h0000_00ff;
      w16:     return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic logic [amba_word-1:0] data_mask(cw_width_t w);
    case (w)
      w8:      return 32'h0000_000f;  // 4 data bits
      w16:     return 32'h0000_07ff;  // 11 data bits
      default: return 32'h03ff_ffff;  // 26 data bits
    endcase
  endfunction

  // highest hamming position in use
  function automatic int unsigned last_pos(cw_width_t w);
    case (w)
      w8:      return 7;
      w16:     return 15;
      default: return 31;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hw/apb_pkg.sv
`default_nettype none

package apb_pkg;

  localparam int paddr_w = 20;
  localparam int pdata_w = 32;

  typedef logic [paddr_w-1:0] paddr_t;

  typedef struct packed {
    logic               psel;
    logic               penable;
    logic               pwrite;
    paddr_t             paddr;
    logic [pdata_w-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [pdata_w-1:0] prdata;
    logic               pready;
  } apb_rsp_t;

  // ----------------------------------------
  // register offsets, paddr[3:0]
  // ----------------------------------------
  localparam logic [3:0] reg_ctrl     = 4'h0;
  localparam logic [3:0] reg_data_in  = 4'h4;
  localparam logic [3:0] reg_cw_width = 4'h8;
  localparam logic [3:0] reg_noise    = 4'hc;

endpackage

`default_nettype wire

//--- hw/ecc_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_apb_regs #(
  parameter int addr_width = 20
) (
  input  wire                 clk,
  input  wire                 rst,
  input  wire apb_pkg::apb_req_t req,
  output apb_pkg::apb_rsp_t   rsp,
  output ecc_pkg::ecc_cmd_t   cmd,
  output logic                start
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } apb_state_t;

  apb_state_t  state;
  apb_state_t  state_nxt;
  logic [3:0]  offset;
  logic        write_en;
  logic [31:0] ctrl_q;
  logic [31:0] data_in_q;
  logic [31:0] cw_width_q;
  logic [31:0] noise_q;
  logic [31:0] rdata;

  if (addr_width < 4) begin : g_addr_check
    $error("addr_width too narrow for the register offsets");
  end

  assign offset = req.paddr[3:0];
  // pready is always high, so access ends on the next edge
  assign write_en = (state == st_setup) && req.psel && req.penable && req.pwrite;

  // ----------------------------------------
  // apb slave fsm
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (req.psel && !req.penable) state_nxt = st_setup;
      end
      st_setup: begin
        if (!req.psel) state_nxt = st_idle;
        else if (req.penable) state_nxt = st_access;
      end
      st_access: begin
        // back to back transfer starts right away
        state_nxt = (req.psel && !req.penable) ? st_setup : st_idle;
      end
      default: state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state <= st_idle;
    else state <= state_nxt;
  end

  // ----------------------------------------
  // register file
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q     <= '0;
      data_in_q  <= '0;
      cw_width_q <= '0;
      noise_q    <= '0;
      start      <= 1'b0;
    end else begin
      start <= write_en && (offset == apb_pkg::reg_ctrl);  // ctrl write kicks off op
      if (write_en) begin
        case (offset)
          apb_pkg::reg_ctrl:     ctrl_q     <= req.pwdata;
          apb_pkg::reg_data_in:  data_in_q  <= req.pwdata;
          apb_pkg::reg_cw_width: cw_width_q <= req.pwdata;
          apb_pkg::reg_noise:    noise_q    <= req.pwdata;
          default: ;  // unmapped
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      apb_pkg::reg_ctrl:     rdata = ctrl_q;
      apb_pkg::reg_data_in:  rdata = data_in_q;
      apb_pkg::reg_cw_width: rdata = cw_width_q;
      apb_pkg::reg_noise:    rdata = noise_q;
      default:               rdata = '0;
    endcase
  end

  always_comb begin
    rsp.prdata = (req.psel && req.penable && !req.pwrite) ? rdata : '0;
    rsp.pready = 1'b1;
  end

  always_comb begin
    cmd.op      = ecc_pkg::ecc_op_t'(ctrl_q[1:0]);
    cmd.width   = ecc_pkg::cw_width_t'(cw_width_q[1:0]);
    cmd.data_in = ecc_pkg::data_word_u'(data_in_q);
    cmd.noise   = noise_q;
  end

  a_start_single : assert property (@(posedge clk) disable iff (rst) start |=> !start)
    else $error("start strobe held for more than one cycle");

endmodule

`default_nettype wire

//--- hw/ecc_codec_core.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_codec_core (
  input  wire                      clk,
  input  wire                      rst,
  input  wire ecc_pkg::ecc_cmd_t   cmd,
  input  wire                      start,
  output ecc_pkg::ecc_core_out_t   core_out,
  output logic                     core_valid
);

  typedef struct packed {
    ecc_pkg::ecc_op_t   op;
    ecc_pkg::cw_width_t width;
    ecc_pkg::codeword_t cw;
  } stage1_t;

  ecc_pkg::codeword_t     enc_cw;
  logic [31:0]            noise_m;
  stage1_t                s1_d;
  stage1_t                s1_q;
  logic                   s1_valid;
  logic [4:0]             syn;
  logic                   par_bad;
  ecc_pkg::codeword_t     fixed;
  logic [1:0]             err;
  ecc_pkg::ecc_core_out_t s2_d;

  function automatic logic is_data_pos(int unsigned pos, int unsigned last);
    return (pos <= last) && ((pos & (pos - 1)) != 0);  // skip powers of two
  endfunction

  function automatic ecc_pkg::codeword_t encode(logic [31:0] data, ecc_pkg::cw_width_t w);
    ecc_pkg::codeword_t cw;
    int unsigned        last;
    int unsigned        j;
    logic               p;
    cw   = '0;
    last = ecc_pkg::last_pos(w);
    j    = 0;
    for (int unsigned pos = 1; pos < 32; pos++) begin
      if (is_data_pos(pos, last)) begin
        cw.body[pos-1] = data[j];
        j++;
      end
    end
    // unused high positions are zero, so their parity comes out 0
    for (int unsigned b = 0; b < 5; b++) begin
      p = 1'b0;
      for (int unsigned pos = 1; pos < 32; pos++) begin
        if (pos[b]) p = p ^ cw.body[pos-1];
      end
      cw.body[(1 << b) - 1] = p;
    end
    cw.parity = ^cw.body;
    return cw;
  endfunction

  function automatic logic [4:0] syndrome(ecc_pkg::codeword_t cw);
    logic [4:0] s;
    s = '0;
    for (int unsigned pos = 1; pos < 32; pos++) begin
      if (cw.body[pos-1]) s = s ^ 5'(pos);
    end
    return s;
  endfunction

  function automatic logic [31:0] extract(ecc_pkg::codeword_t cw, ecc_pkg::cw_width_t w);
    logic [31:0] data;
    int unsigned last;
    int unsigned j;
    data = '0;
    last = ecc_pkg::last_pos(w);
    j    = 0;
    for (int unsigned pos = 1; pos < 32; pos++) begin
      if (is_data_pos(pos, last)) begin
        data[j] = cw.body[pos-1];
        j++;
      end
    end
    return data;
  endfunction

  // ----------------------------------------
  // stage 1: encode, noise
  // ----------------------------------------
  assign enc_cw  = encode(cmd.data_in.raw, cmd.width);
  assign noise_m = cmd.noise & ecc_pkg::cw_mask(cmd.width);

  always_comb begin
    s1_d.op    = cmd.op;
    s1_d.width = cmd.width;
    case (cmd.op)
      ecc_pkg::op_encode:  s1_d.cw = enc_cw;
      ecc_pkg::op_channel: s1_d.cw = ecc_pkg::codeword_t'(enc_cw ^ noise_m);
      default:             s1_d.cw = ecc_pkg::codeword_t'(cmd.data_in.cw &
                                                          ecc_pkg::cw_mask(cmd.width));
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) s1_valid <= 1'b0;
    else s1_valid <= start;
  end

  always_ff @(posedge clk) begin
    if (start) s1_q <= s1_d;
  end

  // ----------------------------------------
  // stage 2: syndrome, correct, extract
  // ----------------------------------------
  always_comb begin
    syn     = syndrome(s1_q.cw);
    par_bad = ^s1_q.cw;
    fixed   = s1_q.cw;
    err     = 2'd0;
    if (syn != 5'd0 && par_bad) begin
      fixed.body[syn - 5'd1] = ~fixed.body[syn - 5'd1];  // single, flip it
      err = 2'd1;
    end else if (syn != 5'd0) begin
      err = 2'd2;  // double, leave as is
    end else if (par_bad) begin
      err = 2'd1;  // overall parity bit only
    end
  end

  always_comb begin
    s2_d.op    = s1_q.op;
    s2_d.width = s1_q.width;
    if (s1_q.op == ecc_pkg::op_encode) begin
      s2_d.value     = s1_q.cw;
      s2_d.err_count = 2'd0;
    end else begin
      s2_d.value     = extract(fixed, s1_q.width);
      s2_d.err_count = err;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) core_valid <= 1'b0;
    else core_valid <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) core_out <= s2_d;
  end

  a_width_legal : assert property (@(posedge clk) disable iff (rst)
    start |-> cmd.width != 2'd3)
    else $error("operation started with reserved codeword width");

endmodule

`default_nettype wire

//--- hw/ecc_result.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_result (
  input  wire                        clk,
  input  wire                        rst,
  input  wire ecc_pkg::ecc_core_out_t core_out,
  input  wire                        core_valid,
  output ecc_pkg::ecc_result_t       result
);

  logic [31:0] mask;

  // codeword width for encode, data width otherwise
  always_comb begin
    if (core_out.op == ecc_pkg::op_encode) begin
      mask = ecc_pkg::cw_mask(core_out.width);
    end else begin
      mask = ecc_pkg::data_mask(core_out.width);
    end
  end

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else begin
      result.done <= core_valid;  // one cycle strobe
      if (core_valid) begin
        result.data_out      <= core_out.value & mask;
        result.num_of_errors <= core_out.err_count;
      end
    end
  end

  a_err_range : assert property (@(posedge clk) disable iff (rst)
    result.num_of_errors != 2'd3)
    else $error("error count out of range");

endmodule

`default_nettype wire

//--- hw/ecc_top.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_top #(
  parameter int addr_width = 20
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          psel,
  input  wire                          penable,
  input  wire                          pwrite,
  input  wire [addr_width-1:0]         paddr,
  input  wire [apb_pkg::pdata_w-1:0]   pwdata,
  output logic [apb_pkg::pdata_w-1:0]  prdata,
  output logic                         pready,
  output logic [ecc_pkg::amba_word-1:0] data_out,
  output logic [1:0]                   num_of_errors,
  output logic                         operation_done
);

  apb_pkg::apb_req_t      req;
  apb_pkg::apb_rsp_t      rsp;
  ecc_pkg::ecc_cmd_t      cmd;
  logic                   start;
  ecc_pkg::ecc_core_out_t core_out;
  logic                   core_valid;
  ecc_pkg::ecc_result_t   result;

  assign req = '{psel: psel, penable: penable, pwrite: pwrite,
                 paddr: apb_pkg::paddr_t'(paddr), pwdata: pwdata};

  assign prdata         = rsp.prdata;
  assign pready         = rsp.pready;
  assign data_out       = result.data_out;
  assign num_of_errors  = result.num_of_errors;
  assign operation_done = result.done;

  ecc_apb_regs #(.addr_width(addr_width)) u_regs (
    .clk(clk), .rst(rst), .req(req), .rsp(rsp), .cmd(cmd), .start(start)
  );

  ecc_codec_core u_core (
    .clk(clk), .rst(rst), .cmd(cmd), .start(start),
    .core_out(core_out), .core_valid(core_valid)
  );

  ecc_result u_result (
    .clk(clk), .rst(rst), .core_out(core_out), .core_valid(core_valid), .result(result)
  );

endmodule

`default_nettype wire

//--- bench/tb_ecc_tasks.svh
`ifndef TB_ECC_TASKS_SVH
`define TB_ECC_TASKS_SVH

// ----------------------------------------
// error counters and expected values
// ----------------------------------------
int          mismatch_count = 0;
int          other_count    = 0;
string       test_name      = "idle";
logic [31:0] exp_rdata      = '0;
logic [31:0] exp_data       = '0;
logic [1:0]  exp_err        = '0;
logic        check_data     = 1'b0;
logic        check_err      = 1'b0;

function automatic int codeword_bits(logic [1:0] w);
  return (w == 2'd0) ? 8 : (w == 2'd1) ? 16 : 32;
endfunction

function automatic logic [31:0] data_bit_mask(logic [1:0] w);
  return (w == 2'd0) ? 32'h0000_000f : (w == 2'd1) ? 32'h0000_07ff : 32'h03ff_ffff;
endfunction

// parity bits come from xor of the positions of set data bits
function automatic logic [31:0] ref_encode(logic [31:0] data, logic [1:0] w);
  logic [31:0] cw;
  logic [4:0]  par;
  int          n;
  int          k;
  cw  = '0;
  par = '0;
  k   = 0;
  n   = codeword_bits(w);
  for (int p = 3; p < n; p++) begin
    if ((p & (p - 1)) != 0) begin
      cw[p] = data[k];
      if (data[k]) par = par ^ 5'(p);
      k++;
    end
  end
  for (int b = 0; b < 5; b++) begin
    if ((1 << b) < n) cw[1 << b] = par[b];
  end
  cw[0] = ^cw[31:1];  // overall parity
  return cw;
endfunction

// ----------------------------------------
// apb transfers, driven on falling edges
// ----------------------------------------
task automatic apb_write(input logic [3:0] off, input logic [31:0] value);
  @(negedge clk);
  psel    = 1'b1;
  penable = 1'b0;
  pwrite  = 1'b1;
  paddr   = 20'(off);
  pwdata  = value;
  @(negedge clk);
  penable = 1'b1;  // access phase
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
  pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [3:0] off, input logic [31:0] expected, input string name);
  @(negedge clk);
  test_name = name;
  exp_rdata = expected;
  psel      = 1'b1;
  penable   = 1'b0;
  pwrite    = 1'b0;
  paddr     = 20'(off);
  @(negedge clk);
  penable = 1'b1;  // prdata checked at the closing edge
  @(negedge clk);
  psel    = 1'b0;
  penable = 1'b0;
endtask

`endif

//--- bench/tb_ecc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_top;

  // about 60 ops of 20 cycles, plus margin
  localparam int n_ops          = 60;
  localparam int op_cycles      = 20;
  localparam int timeout_cycles = n_ops * op_cycles * 3 + 400;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        psel = 1'b0;
  logic        penable = 1'b0;
  logic        pwrite = 1'b0;
  logic [19:0] paddr = '0;
  logic [31:0] pwdata = '0;
  logic [31:0] prdata;
  logic        pready;
  logic [31:0] data_out;
  logic [1:0]  num_of_errors;
  logic        operation_done;
  logic        ctrl_access;
  logic        rd_access;
  int          cycle_count = 0;

  `include "tb_ecc_tasks.svh"

  always #5 clk = ~clk;

  ecc_top #(.addr_width(20)) DUT (
    .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .data_out(data_out), .num_of_errors(num_of_errors), .operation_done(operation_done)
  );

  assign ctrl_access = psel && penable && pwrite && (paddr[3:0] == apb_pkg::reg_ctrl);
  assign rd_access   = psel && penable && !pwrite;

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_done_latency : assert property (@(posedge clk) disable iff (rst)
    ctrl_access |-> ##4 operation_done)
    else begin
      other_count++;
      $display("operation_done missing 4 cycles after ctrl write in %s", test_name);
    end

  a_done_width : assert property (@(posedge clk) disable iff (rst)
    operation_done |=> !operation_done)
    else begin
      other_count++;
      $display("operation_done stayed high for more than one cycle in %s", test_name);
    end

  a_done_cause : assert property (@(posedge clk) disable iff (rst)
    operation_done |-> $past(ctrl_access, 4))
    else begin
      other_count++;
      $display("operation_done rose without a ctrl write in %s", test_name);
    end

  a_data : assert property (@(posedge clk) disable iff (rst)
    operation_done && check_data |-> data_out == exp_data)
    else begin
      mismatch_count++;
      $display("Mismatch %s data_out expected %h actual %h",
               test_name, exp_data, $sampled(data_out));
    end

  a_err_count : assert property (@(posedge clk) disable iff (rst)
    operation_done && check_err |-> num_of_errors == exp_err)
    else begin
      mismatch_count++;
      $display("Mismatch %s num_of_errors expected %0d actual %0d",
               test_name, exp_err, $sampled(num_of_errors));
    end

  a_readback : assert property (@(posedge clk) disable iff (rst)
    rd_access |-> prdata == exp_rdata)
    else begin
      mismatch_count++;
      $display("Mismatch %s prdata expected %h actual %h",
               test_name, exp_rdata, $sampled(prdata));
    end

  a_ready : assert property (@(posedge clk) disable iff (rst) psel && penable |-> pready)
    else begin
      other_count++;
      $display("pready was low during an access phase");
    end

  task automatic run_op(input string name, input logic [1:0] op, input logic [1:0] w,
                        input logic [31:0] din, input logic [31:0] noise,
                        input logic [31:0] exp_value, input logic chk_value,
                        input logic [1:0] exp_count);
    int n;
    apb_write(apb_pkg::reg_cw_width, 32'(w));
    apb_write(apb_pkg::reg_data_in, din);
    apb_write(apb_pkg::reg_noise, noise);
    test_name  = name;
    exp_data   = exp_value;
    check_data = chk_value;
    exp_err    = exp_count;
    check_err  = 1'b1;
    apb_write(apb_pkg::reg_ctrl, 32'(op));
    n = 0;
    while (!operation_done && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!operation_done) begin
      other_count++;
      $display("no operation_done seen for %s", name);
    end
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    int          rng_init;
    int          n;
    int          b0;
    int          b1;
    logic [31:0] v_ctrl;
    logic [31:0] v_data;
    logic [31:0] v_width;
    logic [31:0] v_noise;
    logic [31:0] junk;
    rng_init = $urandom(20);
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_name = "reset_outputs";
    a_reset_out : assert (!operation_done && data_out == '0 && num_of_errors == '0)
      else begin
        mismatch_count++;
        $display("Mismatch %s expected 0 actual done=%b data=%h err=%0d",
                 test_name, operation_done, data_out, num_of_errors);
      end
    apb_read(apb_pkg::reg_ctrl, '0, "reset_ctrl");
    apb_read(apb_pkg::reg_data_in, '0, "reset_data_in");
    apb_read(apb_pkg::reg_cw_width, '0, "reset_cw_width");
    apb_read(apb_pkg::reg_noise, '0, "reset_noise");

    for (int r = 0; r < 3; r++) begin
      v_ctrl  = $urandom;
      v_data  = $urandom;
      v_width = ($urandom & 32'hffff_fffc) | 32'($urandom_range(0, 2));  // keep width legal
      v_noise = $urandom;
      apb_write(apb_pkg::reg_ctrl, v_ctrl);
      apb_write(apb_pkg::reg_data_in, v_data);
      apb_write(apb_pkg::reg_cw_width, v_width);
      apb_write(apb_pkg::reg_noise, v_noise);
      apb_write(4'h2, $urandom);  // unmapped
      apb_read(apb_pkg::reg_ctrl, v_ctrl, "readback_ctrl");
      apb_read(apb_pkg::reg_data_in, v_data, "readback_data_in");
      apb_read(apb_pkg::reg_cw_width, v_width, "readback_cw_width");
      apb_read(apb_pkg::reg_noise, v_noise, "readback_noise");
      apb_read(4'h2, '0, "readback_unmapped");
    end

    for (int w = 0; w < 3; w++) begin
      n = codeword_bits(2'(w));
      junk = $urandom & ~((n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 1));
      for (int i = 0; i < 4; i++) begin
        v_data = $urandom & data_bit_mask(2'(w));
        run_op("encode", ecc_pkg::op_encode, 2'(w), v_data, $urandom,
               ref_encode(v_data, 2'(w)), 1'b1, 2'd0);
        run_op("clean_decode", ecc_pkg::op_decode, 2'(w), ref_encode(v_data, 2'(w)), '0,
               v_data, 1'b1, 2'd0);
      end
      for (int i = 0; i < 5; i++) begin
        v_data = $urandom & data_bit_mask(2'(w));
        b0 = $urandom_range(0, n - 1);
        run_op("single_error", ecc_pkg::op_channel, 2'(w), v_data,
               (32'd1 << b0) | junk, v_data, 1'b1, 2'd1);
        b1 = (b0 + 1 + $urandom_range(0, n - 2)) % n;  // distinct from b0
        run_op("double_error", ecc_pkg::op_channel, 2'(w), v_data,
               (32'd1 << b0) | (32'd1 << b1) | junk, '0, 1'b0, 2'd2);
      end
    end

    repeat (10) @(negedge clk);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles during %s", cycle_count, test_name);
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+bench
hw/ecc_pkg.sv
hw/apb_pkg.sv
hw/ecc_apb_regs.sv
hw/ecc_codec_core.sv
hw/ecc_result.sv
hw/ecc_top.sv
bench/tb_ecc_top.sv
